//--- hdl/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

	// ------------------------------
	// Geometry
	// ------------------------------
	localparam int ADDR_W         = 16; // Byte address
	localparam int DATA_W         = 16;
	localparam int MEM_WORDS      = 256;
	localparam int MEM_LATENCY    = 4;  // Start to valid, in cycles
	localparam int LINES          = 8;
	localparam int WORDS_PER_LINE = 4;

	localparam int MEM_AW   = $clog2(MEM_WORDS);      // Word index into main memory
	localparam int OFFSET_W = $clog2(WORDS_PER_LINE); // 2
	localparam int INDEX_W  = $clog2(LINES);          // 3
	localparam int TAG_W    = ADDR_W - 1 - OFFSET_W - INDEX_W; // 10, bit 0 is the byte bit
	localparam int OFF_LSB  = 1;
	localparam int IDX_LSB  = OFF_LSB + OFFSET_W;
	localparam int TAG_LSB  = IDX_LSB + INDEX_W;
	localparam int TIMER_W  = $clog2(MEM_LATENCY + 1);

	// ------------------------------
	// Encodings
	// ------------------------------
	typedef enum logic {OP_READ, OP_WRITE} mem_op_e;

	typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT_I, ARB_GRANT_D} arb_state_e;

	typedef enum logic [1:0] {C_IDLE, C_FILL, C_WRITE, C_RESP} cache_state_e;

	// Pipeline side of a cache
	typedef struct packed {
		logic              valid; // One-cycle strobe
		mem_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} pipe_req_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] rdata;
	} pipe_rsp_t;

	// Memory side, shared through the arbiter
	typedef struct packed {
		logic              en; // One-cycle start
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/mem_timer.sv
`timescale 1ns/100ps
`default_nettype none

module mem_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic done,
	output logic active
);
	import mem_sys_pkg::*;

	logic [TIMER_W-1:0] count_q; // Cycles left in the open access

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (start) begin
			count_q <= TIMER_W'(MEM_LATENCY);
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign active = (count_q != '0);
	assign done   = (count_q == TIMER_W'(1)); // Last counted cycle, reaches zero at the edge

	// Memory is not pipelined, owner must wait for done
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !active);

endmodule

`default_nettype wire

//--- hdl/main_mem.sv
`timescale 1ns/100ps
`default_nettype none

module main_mem (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mem_sys_pkg::mem_req_t req,
	output mem_sys_pkg::mem_rsp_t rsp
);
	import mem_sys_pkg::*;

	logic [DATA_W-1:0] mem [MEM_WORDS]; // Undefined after reset

	// Latched access
	logic [MEM_AW-1:0] addr_q;
	logic              wr_q;
	logic [DATA_W-1:0] wdata_q;

	logic done;

	// ------------------------------
	// Latency
	// ------------------------------
	mem_timer u_timer (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (req.en),
		.done   (done),
		.active ()
	);

	// ------------------------------
	// Array
	// ------------------------------
	always_ff @(posedge clk) begin
		if (req.en) begin
			addr_q  <= req.addr[MEM_AW:1]; // Word address, upper bits wrap
			wr_q    <= req.wr;
			wdata_q <= req.wdata;
		end
		// Write lands as the timer expires
		if (done && wr_q) begin
			mem[addr_q] <= wdata_q;
		end
	end

	// Read samples the array in the done cycle
	assign rsp.valid = done;
	assign rsp.rdata = mem[addr_q]; // Don't-care for writes

endmodule

`default_nettype wire

//--- hdl/mem_arbiter_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_want,
	input  logic                  i_last,
	input  logic                  d_want,
	input  logic                  d_last,
	input  mem_sys_pkg::mem_req_t i_mreq,
	input  mem_sys_pkg::mem_req_t d_mreq,
	input  mem_sys_pkg::mem_rsp_t mem_rsp,
	output mem_sys_pkg::mem_req_t mreq,
	output mem_sys_pkg::mem_rsp_t i_mrsp,
	output mem_sys_pkg::mem_rsp_t d_mrsp,
	output logic                  grant_i,
	output logic                  grant_d
);
	import mem_sys_pkg::*;

	arb_state_e state_q;

	// ------------------------------
	// Owner selection
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ARB_IDLE;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (i_want) state_q <= ARB_GRANT_I; // I side wins a tie
					else if (d_want) state_q <= ARB_GRANT_D;
				end
				ARB_GRANT_I: if (i_last) state_q <= ARB_IDLE;
				ARB_GRANT_D: if (d_last) state_q <= ARB_IDLE;
				default:     state_q <= ARB_IDLE;
			endcase
		end
	end

	assign grant_i = (state_q == ARB_GRANT_I);
	assign grant_d = (state_q == ARB_GRANT_D);

	// Request mux, idle drives nothing
	always_comb begin
		if (grant_i) mreq = i_mreq;
		else if (grant_d) mreq = d_mreq;
		else mreq = '0;
	end

	// Steer the answer to the owner only
	always_comb begin
		i_mrsp       = mem_rsp;
		d_mrsp       = mem_rsp;
		i_mrsp.valid = mem_rsp.valid & grant_i;
		d_mrsp.valid = mem_rsp.valid & grant_d;
	end

	a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
		!(grant_i && grant_d));

	// Grant must outlive the access it started
	a_rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rsp.valid |-> (grant_i || grant_d));

endmodule

`default_nettype wire

//--- hdl/cache.sv
`timescale 1ns/100ps
`default_nettype none

module cache #(
	parameter bit WRITABLE = 1'b1 // 0 for instruction side
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mem_sys_pkg::pipe_req_t req,
	output mem_sys_pkg::pipe_rsp_t rsp,
	output logic                   busy,
	output logic                   mem_want,
	output logic                   mem_last,
	input  logic                   grant,
	output mem_sys_pkg::mem_req_t  mreq,
	input  mem_sys_pkg::mem_rsp_t  mrsp
);
	import mem_sys_pkg::*;

	// Arrays, valid bits are the only reset part
	logic [LINES-1:0]  valid_q;
	logic [TAG_W-1:0]  tag_mem  [LINES];
	logic [DATA_W-1:0] data_mem [LINES][WORDS_PER_LINE];

	cache_state_e        state_q;
	pipe_req_t           req_q;    // Request being served
	logic [OFFSET_W-1:0] word_cnt; // Fill position
	logic                pending;  // Memory access open
	logic [DATA_W-1:0]   rdata_q;

	logic [INDEX_W-1:0]  idx, q_idx;
	logic [OFFSET_W-1:0] off, q_off;
	logic [TAG_W-1:0]    tag, q_tag;
	logic                hit, is_write, accept, fill_last;

	// ------------------------------
	// Lookup
	// ------------------------------
	assign idx   = req.addr[TAG_LSB-1:IDX_LSB];
	assign off   = req.addr[IDX_LSB-1:OFF_LSB];
	assign tag   = req.addr[ADDR_W-1:TAG_LSB];
	assign q_idx = req_q.addr[TAG_LSB-1:IDX_LSB];
	assign q_off = req_q.addr[IDX_LSB-1:OFF_LSB];
	assign q_tag = req_q.addr[ADDR_W-1:TAG_LSB];

	assign hit       = valid_q[idx] && (tag_mem[idx] == tag);
	assign is_write  = WRITABLE && (req.op == OP_WRITE);
	// New request allowed in idle and in the response cycle, I side drops writes
	assign accept    = req.valid && ((state_q == C_IDLE) || (state_q == C_RESP)) &&
		((req.op == OP_READ) || WRITABLE);
	assign fill_last = (word_cnt == OFFSET_W'(WORDS_PER_LINE - 1));

	// ------------------------------
	// Controller
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= C_IDLE;
			valid_q  <= '0;
			word_cnt <= '0;
			pending  <= 1'b0;
		end else begin
			case (state_q)
				C_IDLE, C_RESP: begin
					state_q <= C_IDLE;
					if (accept) begin
						word_cnt <= '0;
						if (is_write) state_q <= C_WRITE; // Write-through, hit or not
						else if (hit) state_q <= C_RESP;
						else state_q <= C_FILL;
					end
				end
				C_FILL, C_WRITE: begin
					if (mreq.en) pending <= 1'b1;
					if (mrsp.valid) begin
						pending  <= 1'b0;
						word_cnt <= word_cnt + 1'b1;
						if (state_q == C_WRITE) begin
							state_q <= C_RESP;
						end else if (fill_last) begin
							valid_q[q_idx] <= 1'b1; // Line complete
							state_q        <= C_RESP;
						end
					end
				end
				default: state_q <= C_IDLE;
			endcase
		end
	end

	// Payload and arrays
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
			if (hit) rdata_q <= data_mem[idx][off];
			if (is_write && hit) data_mem[idx][off] <= req.wdata; // Update on hit only
		end
		if ((state_q == C_FILL) && mrsp.valid) begin
			data_mem[q_idx][word_cnt] <= mrsp.rdata;
			if (word_cnt == q_off) rdata_q <= mrsp.rdata; // Requested word
			if (fill_last) tag_mem[q_idx] <= q_tag;
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------
	assign busy      = (state_q == C_FILL) || (state_q == C_WRITE);
	assign mem_want  = busy;
	assign mem_last  = mrsp.valid && ((state_q == C_WRITE) || ((state_q == C_FILL) && fill_last));
	assign rsp.valid = (state_q == C_RESP);
	assign rsp.rdata = rdata_q;

	always_comb begin
		mreq.en    = grant && busy && !pending; // One access at a time
		mreq.wr    = (state_q == C_WRITE);
		mreq.addr  = mreq.wr ? req_q.addr : {q_tag, q_idx, word_cnt, 1'b0};
		mreq.wdata = req_q.wdata;
	end

	a_req_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !req.valid);

	// Memory answers only an access this cache opened
	a_rsp_pending: assert property (@(posedge clk) disable iff (!rst_n)
		mrsp.valid |-> pending);

endmodule

`default_nettype wire

//--- hdl/mem_system.sv
`timescale 1ns/100ps
`default_nettype none

module mem_system (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mem_sys_pkg::pipe_req_t i_req,
	output mem_sys_pkg::pipe_rsp_t i_rsp,
	output logic                   i_busy,
	input  mem_sys_pkg::pipe_req_t d_req,
	output mem_sys_pkg::pipe_rsp_t d_rsp,
	output logic                   d_busy
);
	import mem_sys_pkg::*;

	// ------------------------------
	// Cache to arbiter
	// ------------------------------
	mem_req_t i_mreq, d_mreq, mreq;
	mem_rsp_t i_mrsp, d_mrsp, mrsp;
	logic     i_want, i_last, d_want, d_last;
	logic     grant_i, grant_d;

	cache #(.WRITABLE(1'b0)) i_cache ( // Fetch side, reads only
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (i_req),
		.rsp      (i_rsp),
		.busy     (i_busy),
		.mem_want (i_want),
		.mem_last (i_last),
		.grant    (grant_i),
		.mreq     (i_mreq),
		.mrsp     (i_mrsp)
	);

	cache #(.WRITABLE(1'b1)) d_cache (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (d_req),
		.rsp      (d_rsp),
		.busy     (d_busy),
		.mem_want (d_want),
		.mem_last (d_last),
		.grant    (grant_d),
		.mreq     (d_mreq),
		.mrsp     (d_mrsp)
	);

	mem_arbiter_fsm u_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_want  (i_want),
		.i_last  (i_last),
		.d_want  (d_want),
		.d_last  (d_last),
		.i_mreq  (i_mreq),
		.d_mreq  (d_mreq),
		.mem_rsp (mrsp),
		.mreq    (mreq),
		.i_mrsp  (i_mrsp),
		.d_mrsp  (d_mrsp),
		.grant_i (grant_i),
		.grant_d (grant_d)
	);

	main_mem u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (mreq),
		.rsp   (mrsp)
	);

endmodule

`default_nettype wire

//--- verification/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD = 10 // ns
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk; // Even duty cycle

endmodule

`default_nettype wire

//--- verification/tb_mem_system.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_system;
	import mem_sys_pkg::*;

	localparam int TIMEOUT   = 200; // Cycles allowed per response
	localparam int N_IREADS  = 100;
	localparam int N_DOPS    = 400;
	localparam int N_ROUNDS  = 16;

	logic      clk;
	logic      rst_n;
	pipe_req_t i_req, d_req;
	pipe_rsp_t i_rsp, d_rsp;
	logic      i_busy, d_busy;

	logic [DATA_W-1:0] model [MEM_WORDS]; // Expected memory contents by word

	clk_gen #(.PERIOD(10)) u_clk (.clk(clk));

	mem_system dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_req  (i_req),
		.i_rsp  (i_rsp),
		.i_busy (i_busy),
		.d_req  (d_req),
		.d_rsp  (d_rsp),
		.d_busy (d_busy)
	);

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic report_hang(input string port);
		$display("Timeout: the %s port never answered", port);
		$display("TB FAILED");
		$fatal(1, "Stopped on a hung port");
	endtask

	// Single request on one port with its answer data and latency
	task automatic port_access(input bit on_i, input bit write, input logic [15:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata, output int cycles);
		pipe_req_t req;
		pipe_rsp_t rsp;
		string     name;
		if (on_i) name = "i";
		else name = "d";
		check_value({name, "_busy"}, 0, 32'(on_i ? i_busy : d_busy)); // Port must be free
		req.valid = 1'b1;
		if (write) req.op = OP_WRITE;
		else req.op = OP_READ;
		req.addr  = addr;
		req.wdata = wdata;
		if (on_i) i_req = req;
		else d_req = req;
		cycles = 0;
		do begin
			@(negedge clk);
			i_req.valid = 1'b0; // Single-cycle strobe
			d_req.valid = 1'b0;
			cycles++;
			rsp = on_i ? i_rsp : d_rsp;
			if (!rsp.valid) begin
				// Open until the answer
				check_value({name, "_busy"}, 1, 32'(on_i ? i_busy : d_busy));
			end
			if (!rsp.valid && cycles >= TIMEOUT) report_hang(on_i ? "instruction" : "data");
		end while (!rsp.valid);
		check_value({name, "_busy"}, 0, 32'(on_i ? i_busy : d_busy)); // Drops with the answer
		rdata = rsp.rdata;
	endtask

	// Both ports strobed in the same cycle
	task automatic dual_read(input logic [15:0] i_addr, input logic [15:0] d_addr,
		output logic [15:0] i_data, output logic [15:0] d_data,
		output int i_cycles, output int d_cycles);
		int cycles;
		bit i_done;
		bit d_done;
		check_value("i_busy", 0, 32'(i_busy));
		check_value("d_busy", 0, 32'(d_busy));
		i_req  = '{valid: 1'b1, op: OP_READ, addr: i_addr, wdata: 16'h0000};
		d_req  = '{valid: 1'b1, op: OP_READ, addr: d_addr, wdata: 16'h0000};
		cycles = 0;
		i_done = 1'b0;
		d_done = 1'b0;
		while (!(i_done && d_done)) begin
			@(negedge clk);
			i_req.valid = 1'b0;
			d_req.valid = 1'b0;
			cycles++;
			if (!i_done && i_rsp.valid) begin
				i_done   = 1'b1;
				i_data   = i_rsp.rdata;
				i_cycles = cycles;
				check_value("i_busy", 0, 32'(i_busy));
			end
			if (!d_done && d_rsp.valid) begin
				d_done   = 1'b1;
				d_data   = d_rsp.rdata;
				d_cycles = cycles;
				check_value("d_busy", 0, 32'(d_busy));
			end
			if (!i_done) check_value("i_busy", 1, 32'(i_busy));
			if (!d_done) check_value("d_busy", 1, 32'(d_busy));
			if (cycles >= TIMEOUT) begin
				if (!i_done) report_hang("instruction");
				if (!d_done) report_hang("data");
			end
		end
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		logic [31:0] rng;
		logic [15:0] addr, i_addr, d_addr;
		logic [15:0] rdata, i_data, d_data;
		int          cycles, i_cycles, d_cycles;

		rng   = 32'h2e46eec5;
		rst_n = 1'b0;
		i_req = '0;
		d_req = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Quiet after reset
		check_value("i_busy", 0, 32'(i_busy));
		check_value("d_busy", 0, 32'(d_busy));
		check_value("i_rsp.valid", 0, 32'(i_rsp.valid));
		check_value("d_rsp.valid", 0, 32'(d_rsp.valid));

		// Write misses during preload leave the data cache cold
		for (int n = 0; n < MEM_WORDS; n++) begin
			rng  = xorshift32(rng);
			addr = 16'(n << 1);
			port_access(1'b0, 1'b1, addr, rng[15:0], rdata, cycles);
			model[n] = rng[15:0];
		end

		// Lower half fetches where the repeat must hit
		for (int n = 0; n < N_IREADS; n++) begin
			rng  = xorshift32(rng);
			addr = {8'h00, rng[7:0]};
			port_access(1'b1, 1'b0, addr, 16'h0000, rdata, cycles);
			check_value("i_rsp.rdata", 32'(model[addr[8:1]]), 32'(rdata));
			port_access(1'b1, 1'b0, addr, 16'h0000, rdata, cycles);
			check_value("i_rsp.rdata", 32'(model[addr[8:1]]), 32'(rdata));
			check_value("i_hit_cycles", 1, cycles);
		end

		// Fetch port drops a write without busy or answer
		rng   = xorshift32(rng);
		addr  = {8'h00, rng[7:0]};
		i_req = '{valid: 1'b1, op: OP_WRITE, addr: addr, wdata: ~model[addr[8:1]]};
		@(negedge clk);
		i_req.valid = 1'b0;
		check_value("i_busy", 0, 32'(i_busy));
		check_value("i_rsp.valid", 0, 32'(i_rsp.valid));
		port_access(1'b1, 1'b0, addr, 16'h0000, rdata, cycles);
		check_value("i_rsp.rdata", 32'(model[addr[8:1]]), 32'(rdata));
		port_access(1'b0, 1'b0, addr, 16'h0000, rdata, cycles); // Memory left untouched
		check_value("d_rsp.rdata", 32'(model[addr[8:1]]), 32'(rdata));

		// Upper half loads and stores with 4 tags per index
		for (int n = 0; n < N_DOPS; n++) begin
			rng  = xorshift32(rng);
			addr = {7'h00, 1'b1, rng[7:0]}; // Random bit 0 is ignored by the DUT
			if (rng[8]) begin
				port_access(1'b0, 1'b1, addr, rng[31:16], rdata, cycles);
				model[addr[8:1]] = rng[31:16];
			end else begin
				port_access(1'b0, 1'b0, addr, 16'h0000, rdata, cycles);
				check_value("d_rsp.rdata", 32'(model[addr[8:1]]), 32'(rdata));
			end
		end

		// Both ports miss together on lines kept cold by unique high bits
		for (int n = 0; n < N_ROUNDS; n++) begin
			rng    = xorshift32(rng);
			i_addr = {7'(n + 1), 1'b0, rng[7:0]};
			d_addr = {7'(n + 1), 1'b1, rng[15:8]};
			dual_read(i_addr, d_addr, i_data, d_data, i_cycles, d_cycles);
			check_value("i_rsp.rdata", 32'(model[i_addr[8:1]]), 32'(i_data));
			check_value("d_rsp.rdata", 32'(model[d_addr[8:1]]), 32'(d_data));
			check_value("i_wins_tie", 1, 32'(i_cycles < d_cycles)); // Fetch side first
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
hdl/mem_sys_pkg.sv
hdl/mem_timer.sv
hdl/main_mem.sv
hdl/mem_arbiter_fsm.sv
hdl/cache.sv
hdl/mem_system.sv
verification/clk_gen.sv
verification/tb_mem_system.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_system -f src.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

grep -q "^TB PASSED$" sim.log
echo "Simulation passed"
